/* logic/vout_pkg.sv */
`default_nettype none

package vout_pkg;

	// --------------------------------------------------
	//  Wishbone bus types
	// --------------------------------------------------

	// Word address, byte address bits 31..2
	typedef logic [31:2] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	// Host to slave
	typedef struct packed {
		wb_adr_t adr;
		wb_dat_t dat;
		logic    we;
		wb_sel_t sel;
		logic    cyc;
		logic    stb;
	} wb_req_t;

	// Slave to host
	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_rsp_t;

	// Address map, page at bits 31..12
	localparam logic [19:0] VIDEO_PAGE = 20'h40010;
	localparam logic [19:0] GPIO_PAGE  = 20'h40021;

	// Register index starts at byte address bit 2
	localparam int REG_INDEX_LSB = 2;

	// GPIO register indexes
	typedef enum logic [1:0] {
		GPIO_DATA      = 2'd0,
		GPIO_DIRECTION = 2'd1
	} gpio_reg_e;

	// Video timing register indexes
	typedef enum logic [1:0] {
		VT_CONTROL  = 2'd0,
		VT_H_ACTIVE = 2'd1,
		VT_V_ACTIVE = 2'd2
	} vtiming_reg_e;

	// --------------------------------------------------
	//  Video types
	// --------------------------------------------------

	typedef logic [11:0] coord_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	typedef struct packed {
		logic   vsync;
		logic   hsync;
		logic   de;
		pixel_t pixel;
	} video_t;

	// Line and frame phases, in running order
	typedef enum logic [1:0] {
		PH_SYNC   = 2'd0,
		PH_BACK   = 2'd1,
		PH_ACTIVE = 2'd2,
		PH_FRONT  = 2'd3
	} vphase_e;

	// Byte lane merge for register writes
	function automatic wb_dat_t wb_merge(wb_dat_t old_dat, wb_dat_t new_dat, wb_sel_t sel);
		wb_dat_t res;
		for (int i = 0; i < 4; i++) begin
			res[8*i +: 8] = sel[i] ? new_dat[8*i +: 8] : old_dat[8*i +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

/* logic/wb_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
	input  wire vout_pkg::wb_req_t wb_req_i,
	output vout_pkg::wb_rsp_t      wb_rsp_o,

	output vout_pkg::wb_req_t      gpio_req_o,
	input  wire vout_pkg::wb_rsp_t gpio_rsp_i,

	output vout_pkg::wb_req_t      video_req_o,
	input  wire vout_pkg::wb_rsp_t video_rsp_i
);

	logic gpio_hit;
	logic video_hit;
	logic host_access;

	// --------------------------------------------------
	//  Slave select
	// --------------------------------------------------

	// Page compare on upper address bits
	assign gpio_hit    = (wb_req_i.adr[31:12] == vout_pkg::GPIO_PAGE);
	assign video_hit   = (wb_req_i.adr[31:12] == vout_pkg::VIDEO_PAGE);
	assign host_access = wb_req_i.cyc & wb_req_i.stb;

	// Same request to both slaves, stb only where the page matches
	always_comb begin
		gpio_req_o      = wb_req_i;
		gpio_req_o.stb  = host_access & gpio_hit;

		video_req_o     = wb_req_i;
		video_req_o.stb = host_access & video_hit;
	end

	// --------------------------------------------------
	//  Response select
	// --------------------------------------------------

	always_comb begin
		if (video_hit) begin
			wb_rsp_o = video_rsp_i;
		end else if (gpio_hit) begin
			wb_rsp_o = gpio_rsp_i;
		end else begin
			// Unmapped page reads zero
			wb_rsp_o.dat = '0;
			// Acked in the same cycle so the host never hangs
			wb_rsp_o.ack = host_access;
		end
	end

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
	parameter int                    GPIO_WIDTH     = 4,
	parameter logic [GPIO_WIDTH-1:0] INIT_DIRECTION = '1,
	parameter logic [GPIO_WIDTH-1:0] INIT_OUTPUT    = '0
) (
	input  wire                    clk_i,
	input  wire                    rst_i,

	input  wire vout_pkg::wb_req_t wb_req_i,
	output vout_pkg::wb_rsp_t      wb_rsp_o,

	input  wire [GPIO_WIDTH-1:0]   gpio_i,
	output logic [GPIO_WIDTH-1:0]  gpio_o,
	output logic [GPIO_WIDTH-1:0]  gpio_oe_o
);

	vout_pkg::gpio_reg_e  reg_index;
	vout_pkg::wb_dat_t    merged;
	logic                 access;
	logic                 ack_q;
	logic [GPIO_WIDTH-1:0] pin_state;

	assign reg_index = vout_pkg::gpio_reg_e'(wb_req_i.adr[vout_pkg::REG_INDEX_LSB +: 2]);

	// New access only when not already acking
	assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// Old register value under byte selects, per index
	always_comb begin
		case (reg_index)
			vout_pkg::GPIO_DIRECTION:
				merged = vout_pkg::wb_merge(vout_pkg::wb_dat_t'(gpio_oe_o),
				                            wb_req_i.dat, wb_req_i.sel);
			default:
				merged = vout_pkg::wb_merge(vout_pkg::wb_dat_t'(gpio_o),
				                            wb_req_i.dat, wb_req_i.sel);
		endcase
	end

	// --------------------------------------------------
	//  Registers and ack
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q     <= 1'b0;
			gpio_o    <= INIT_OUTPUT;
			gpio_oe_o <= INIT_DIRECTION;
		end else begin
			// One cycle ack
			ack_q <= access;
			if (access && wb_req_i.we) begin
				case (reg_index)
					vout_pkg::GPIO_DATA:      gpio_o    <= GPIO_WIDTH'(merged);
					vout_pkg::GPIO_DIRECTION: gpio_oe_o <= GPIO_WIDTH'(merged);
					default: ;
				endcase
			end
		end
	end

	// Driven bits read back the output register, inputs read the pin
	assign pin_state = (gpio_o & gpio_oe_o) | (gpio_i & ~gpio_oe_o);

	// Readback, held stable by the host while ack is high
	always_comb begin
		case (reg_index)
			vout_pkg::GPIO_DATA:      wb_rsp_o.dat = vout_pkg::wb_dat_t'(pin_state);
			vout_pkg::GPIO_DIRECTION: wb_rsp_o.dat = vout_pkg::wb_dat_t'(gpio_oe_o);
			default:                  wb_rsp_o.dat = '0;
		endcase
		wb_rsp_o.ack = ack_q;
	end

endmodule

`default_nettype wire

/* logic/vtiming_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vtiming_regs #(
	parameter vout_pkg::coord_t INIT_H_ACTIVE = 12'd640,
	parameter vout_pkg::coord_t INIT_V_ACTIVE = 12'd480
) (
	input  wire                    clk_i,
	input  wire                    rst_i,

	input  wire vout_pkg::wb_req_t wb_req_i,
	output vout_pkg::wb_rsp_t      wb_rsp_o,

	output logic                   enable_o,
	output vout_pkg::coord_t       h_active_o,
	output vout_pkg::coord_t       v_active_o
);

	vout_pkg::vtiming_reg_e reg_index;
	vout_pkg::wb_dat_t      cur_dat;
	vout_pkg::wb_dat_t      merged;
	logic                   access;
	logic                   ack_q;

	assign reg_index = vout_pkg::vtiming_reg_e'(wb_req_i.adr[vout_pkg::REG_INDEX_LSB +: 2]);
	assign access    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// Current value of the addressed register
	always_comb begin
		case (reg_index)
			vout_pkg::VT_CONTROL:  cur_dat = vout_pkg::wb_dat_t'(enable_o);
			vout_pkg::VT_H_ACTIVE: cur_dat = vout_pkg::wb_dat_t'(h_active_o);
			vout_pkg::VT_V_ACTIVE: cur_dat = vout_pkg::wb_dat_t'(v_active_o);
			default:               cur_dat = '0;
		endcase
	end

	assign merged = vout_pkg::wb_merge(cur_dat, wb_req_i.dat, wb_req_i.sel);

	// --------------------------------------------------
	//  Control, width and height
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q      <= 1'b0;
			enable_o   <= 1'b0;
			h_active_o <= INIT_H_ACTIVE;
			v_active_o <= INIT_V_ACTIVE;
		end else begin
			ack_q <= access;
			if (access && wb_req_i.we) begin
				case (reg_index)
					// Bit 0 is the generator enable
					vout_pkg::VT_CONTROL:  enable_o   <= merged[0];
					vout_pkg::VT_H_ACTIVE: h_active_o <= vout_pkg::coord_t'(merged);
					vout_pkg::VT_V_ACTIVE: v_active_o <= vout_pkg::coord_t'(merged);
					default: ;
				endcase
			end
		end
	end

	assign wb_rsp_o.dat = cur_dat;
	assign wb_rsp_o.ack = ack_q;

endmodule

`default_nettype wire

/* logic/vtiming_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vtiming_gen #(
	parameter int H_SYNC  = 96,
	parameter int H_BACK  = 48,
	parameter int H_FRONT = 16,
	parameter int V_SYNC  = 2,
	parameter int V_BACK  = 33,
	parameter int V_FRONT = 10
) (
	input  wire                   clk_i,
	input  wire                   rst_i,

	input  wire                   enable_i,
	input  wire vout_pkg::coord_t h_active_i,
	input  wire vout_pkg::coord_t v_active_i,

	output vout_pkg::video_t      video_o
);

	vout_pkg::vphase_e h_phase;
	vout_pkg::vphase_e v_phase;
	vout_pkg::coord_t  h_cnt;
	vout_pkg::coord_t  v_cnt;
	vout_pkg::coord_t  h_size;
	vout_pkg::coord_t  v_size;
	vout_pkg::coord_t  h_len;
	vout_pkg::coord_t  v_len;
	logic              h_last;
	logic              v_last;
	logic              line_end;
	logic              frame_end;
	logic              active;

	// Length of a phase in cycles or lines
	function automatic vout_pkg::coord_t phase_len(vout_pkg::vphase_e ph, int sync_len,
	                                               int back_len, vout_pkg::coord_t act_len,
	                                               int front_len);
		case (ph)
			vout_pkg::PH_SYNC:   return vout_pkg::coord_t'(sync_len);
			vout_pkg::PH_BACK:   return vout_pkg::coord_t'(back_len);
			vout_pkg::PH_ACTIVE: return act_len;
			default:             return vout_pkg::coord_t'(front_len);
		endcase
	endfunction

	// Sync, back porch, active, front porch, then around again
	function automatic vout_pkg::vphase_e phase_next(vout_pkg::vphase_e ph);
		return vout_pkg::vphase_e'(ph + 2'd1);
	endfunction

	assign h_len = phase_len(h_phase, H_SYNC, H_BACK, h_size, H_FRONT);
	assign v_len = phase_len(v_phase, V_SYNC, V_BACK, v_size, V_FRONT);

	// A zero length phase still takes one step
	assign h_last    = (h_cnt + 1'b1) >= h_len;
	assign v_last    = (v_cnt + 1'b1) >= v_len;
	assign line_end  = h_last & (h_phase == vout_pkg::PH_FRONT);
	assign frame_end = line_end & v_last & (v_phase == vout_pkg::PH_FRONT);
	assign active    = (h_phase == vout_pkg::PH_ACTIVE) & (v_phase == vout_pkg::PH_ACTIVE);

	// --------------------------------------------------
	//  Phase counters
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i || !enable_i) begin
			// Parked at frame start, sizes follow the registers
			h_phase <= vout_pkg::PH_SYNC;
			v_phase <= vout_pkg::PH_SYNC;
			h_cnt   <= '0;
			v_cnt   <= '0;
			h_size  <= h_active_i;
			v_size  <= v_active_i;
		end else begin
			if (h_last) begin
				h_cnt   <= '0;
				h_phase <= phase_next(h_phase);
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// Vertical steps once per line
			if (line_end) begin
				if (v_last) begin
					v_cnt   <= '0;
					v_phase <= phase_next(v_phase);
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end

			// New sizes only between frames
			if (frame_end) begin
				h_size <= h_active_i;
				v_size <= v_active_i;
			end
		end
	end

	// --------------------------------------------------
	//  Registered output
	// --------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i || !enable_i) begin
			video_o <= '0;
		end else begin
			video_o.hsync <= (h_phase == vout_pkg::PH_SYNC);
			// Whole lines of vertical sync
			video_o.vsync <= (v_phase == vout_pkg::PH_SYNC);
			video_o.de    <= active;
			if (active) begin
				// Counters inside the active phase are x and y
				video_o.pixel.red   <= h_cnt[7:0];
				video_o.pixel.green <= v_cnt[7:0];
				video_o.pixel.blue  <= h_cnt[7:0] ^ v_cnt[7:0];
			end else begin
				video_o.pixel <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/vout_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vout_top #(
	parameter int                    GPIO_WIDTH     = 4,
	parameter logic [GPIO_WIDTH-1:0] INIT_DIRECTION = 4'b1111,
	parameter logic [GPIO_WIDTH-1:0] INIT_OUTPUT    = 4'b0101,
	parameter vout_pkg::coord_t      INIT_H_ACTIVE  = 12'd8,
	parameter vout_pkg::coord_t      INIT_V_ACTIVE  = 12'd4,
	parameter int                    H_SYNC         = 4,
	parameter int                    H_BACK         = 3,
	parameter int                    H_FRONT        = 2,
	parameter int                    V_SYNC         = 1,
	parameter int                    V_BACK         = 1,
	parameter int                    V_FRONT        = 1
) (
	input  wire                    clk_i,
	input  wire                    rst_i,

	input  wire vout_pkg::wb_req_t wb_req_i,
	output vout_pkg::wb_rsp_t      wb_rsp_o,

	input  wire [GPIO_WIDTH-1:0]   gpio_i,
	output wire [GPIO_WIDTH-1:0]   gpio_o,
	output wire [GPIO_WIDTH-1:0]   gpio_oe_o,

	output vout_pkg::video_t       video_o
);

	wire vout_pkg::wb_req_t gpio_req;
	wire vout_pkg::wb_rsp_t gpio_rsp;
	wire vout_pkg::wb_req_t video_req;
	wire vout_pkg::wb_rsp_t video_rsp;

	wire                    enable;
	wire vout_pkg::coord_t  h_active;
	wire vout_pkg::coord_t  v_active;

	// --------------------------------------------------
	//  Bus side
	// --------------------------------------------------

	wb_addr_decode u_decode (
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.gpio_req_o  (gpio_req),
		.gpio_rsp_i  (gpio_rsp),
		.video_req_o (video_req),
		.video_rsp_i (video_rsp)
	);

	gpio_regs #(
		.GPIO_WIDTH     (GPIO_WIDTH),
		.INIT_DIRECTION (INIT_DIRECTION),
		.INIT_OUTPUT    (INIT_OUTPUT)
	) u_gpio (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_req_i  (gpio_req),
		.wb_rsp_o  (gpio_rsp),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

	vtiming_regs #(
		.INIT_H_ACTIVE (INIT_H_ACTIVE),
		.INIT_V_ACTIVE (INIT_V_ACTIVE)
	) u_vregs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_req_i   (video_req),
		.wb_rsp_o   (video_rsp),
		.enable_o   (enable),
		.h_active_o (h_active),
		.v_active_o (v_active)
	);

	// Video timing and test pattern
	vtiming_gen #(
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.H_FRONT (H_FRONT),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK),
		.V_FRONT (V_FRONT)
	) u_vgen (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.enable_i   (enable),
		.h_active_i (h_active),
		.v_active_i (v_active),
		.video_o    (video_o)
	);

endmodule

`default_nettype wire

/* sim/tb_vout_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vout_top;

	localparam int H_SYNC    = 4;
	localparam int H_BACK    = 3;
	localparam int H_FRONT   = 2;
	localparam int V_SYNC    = 1;
	localparam int V_BACK    = 1;
	localparam int V_FRONT   = 1;
	localparam int MAX_CMDS  = 128;
	localparam int ACK_LIMIT = 16;

	logic              clk;
	logic              rst;
	vout_pkg::wb_req_t wb_req;
	vout_pkg::wb_rsp_t wb_rsp;
	logic [3:0]        gpio_in;
	logic [3:0]        gpio_out;
	logic [3:0]        gpio_oe;
	vout_pkg::video_t  video;

	// One entry per trace command line
	logic [7:0]  cmd_list   [0:MAX_CMDS-1];
	logic [31:0] arg_a_list [0:MAX_CMDS-1];
	logic [31:0] arg_b_list [0:MAX_CMDS-1];
	int          line_list  [0:MAX_CMDS-1];
	int          cmd_count   = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	vout_top #(
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.H_FRONT (H_FRONT),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK),
		.V_FRONT (V_FRONT)
	) vout_top_i (
		.clk_i     (clk),
		.rst_i     (rst),
		.wb_req_i  (wb_req),
		.wb_rsp_o  (wb_rsp),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.gpio_oe_o (gpio_oe),
		.video_o   (video)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	//  Failure reporting
	// --------------------------------------------------

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Cycle budget for the whole run
	initial begin
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				abort_run($sformatf("timeout after %0d cycles, run did not finish", cycle_count));
			end
		end
	end

	// --------------------------------------------------
	//  Trace loading
	// --------------------------------------------------

	task automatic load_trace();
		int                fd;
		int                n;
		int                line_no;
		logic [8*160-1:0]  line_buf;
		logic [7:0]        c;
		logic [31:0]       a;
		logic [31:0]       b;
		fd = $fopen("sim/vout_trace.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open trace file sim/vout_trace.txt");
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line_buf = '0;
			n = $fgets(line_buf, fd);
			line_no++;
			c = 8'h00;
			a = '0;
			b = '0;
			n = $sscanf(line_buf, " %c %h %h", c, a, b);
			// Blank lines and comments skipped
			if (n >= 1 && c != "#") begin
				if (n < 2 || (n < 3 && c != "D")) begin
					abort_run($sformatf("trace line %0d is missing values", line_no));
				end
				if (cmd_count >= MAX_CMDS) begin
					abort_run("trace file holds too many commands");
				end
				cmd_list[cmd_count]   = c;
				arg_a_list[cmd_count] = a;
				arg_b_list[cmd_count] = b;
				line_list[cmd_count]  = line_no;
				cmd_count++;
			end
		end
		$fclose(fd);
	endtask

	// Budget of 16 cycles per bus command and 3 frames per frame check plus idle and margin
	function automatic int compute_limit();
		int i;
		int max_w;
		int max_h;
		int frame_len;
		int limit;
		max_w = 0;
		max_h = 0;
		for (i = 0; i < cmd_count; i++) begin
			if (cmd_list[i] == "F" && arg_a_list[i] > max_w) max_w = arg_a_list[i];
			if (cmd_list[i] == "F" && arg_b_list[i] > max_h) max_h = arg_b_list[i];
		end
		frame_len = (H_SYNC + H_BACK + max_w + H_FRONT) * (V_SYNC + V_BACK + max_h + V_FRONT);
		limit = 100;
		for (i = 0; i < cmd_count; i++) begin
			case (cmd_list[i])
				"F":     limit += 3 * frame_len;
				"D":     limit += arg_a_list[i];
				default: limit += ACK_LIMIT;
			endcase
		end
		return limit;
	endfunction

	// --------------------------------------------------
	//  Bus and video tasks
	// --------------------------------------------------

	// One classic cycle that starts and ends 1 ns after a rising edge
	task automatic bus_cycle(input logic we, input logic [31:0] addr,
	                         input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		wb_req.adr = addr[31:2];
		wb_req.dat = wdata;
		wb_req.we  = we;
		wb_req.sel = 4'hf;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		waited = 1;
		@(posedge clk);
		#1;
		while (!wb_rsp.ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!wb_rsp.ack) begin
			abort_run($sformatf("no Wishbone ack within %0d cycles at address %h",
			                    ACK_LIMIT, addr));
		end
		rdata      = wb_rsp.dat;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		// One idle cycle between bus cycles
		@(posedge clk);
		#1;
	endtask

	// Parked generator drives an all zero video word
	task automatic check_disabled(input int cycles, input string name);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(posedge clk);
			#1;
			check_value({name, " video while disabled"}, 32'd0, 32'(video));
		end
	endtask

	// Frame from vsync start up to the next vsync rise
	task automatic check_frame(input int exp_w, input int exp_h, input string name);
		int         x;
		int         y;
		int         hs_pos;
		int         line_len;
		logic       prev_de;
		logic       prev_vsync;
		logic       prev_hsync;
		logic       done;
		logic [7:0] xb;
		logic [7:0] yb;
		// Already inside the vsync line counts as frame start
		while (!video.vsync) begin
			@(posedge clk);
			#1;
		end
		x          = 0;
		y          = 0;
		// Cycles since the last hsync rise, negative until one is seen
		hs_pos     = -1;
		line_len   = H_SYNC + H_BACK + exp_w + H_FRONT;
		prev_de    = 1'b0;
		prev_vsync = 1'b1;
		prev_hsync = video.hsync;
		done       = 1'b0;
		while (!done) begin
			@(posedge clk);
			#1;
			if (video.vsync && !prev_vsync) begin
				// New frame opens with its first hsync
				check_value({name, " hsync at vsync rise"}, 32'd1, 32'(video.hsync));
				done = 1'b1;
			end else begin
				if (hs_pos >= 0) begin
					hs_pos++;
				end
				// Line period and sync width
				if (video.hsync && !prev_hsync) begin
					if (hs_pos >= 0) begin
						check_value($sformatf("%s line length", name), line_len, hs_pos);
					end
					hs_pos = 0;
				end else if (!video.hsync && prev_hsync && hs_pos >= 0) begin
					check_value($sformatf("%s hsync width", name), H_SYNC, hs_pos);
				end
				if (video.de) begin
					// Active pixels follow sync and back porch
					if (!prev_de && hs_pos >= 0) begin
						check_value($sformatf("%s de start in line %0d", name, y),
						            H_SYNC + H_BACK, hs_pos);
					end
					xb = x[7:0];
					yb = y[7:0];
					check_value($sformatf("%s pixel x %0d y %0d", name, x, y),
					            {8'h00, xb, yb, xb ^ yb}, 32'(video.pixel));
					x++;
				end else begin
					if (prev_de) begin
						// Falling de ends one line
						check_value($sformatf("%s width of line %0d", name, y), exp_w, x);
						x = 0;
						y++;
					end
					check_value({name, " pixel outside de"}, 32'd0, 32'(video.pixel));
				end
				prev_de    = video.de;
				prev_vsync = video.vsync;
				prev_hsync = video.hsync;
			end
		end
		check_value({name, " active lines"}, exp_h, y);
	endtask

	// --------------------------------------------------
	//  Main sequence
	// --------------------------------------------------

	initial begin
		int          i;
		logic [31:0] rdata;
		string       name;
		rst     = 1'b1;
		wb_req  = '0;
		gpio_in = 4'b1010;
		load_trace();
		cycle_limit = compute_limit();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (i = 0; i < cmd_count; i++) begin
			name = $sformatf("trace line %0d", line_list[i]);
			case (cmd_list[i])
				"W": bus_cycle(1'b1, arg_a_list[i], arg_b_list[i], rdata);
				"R": begin
					bus_cycle(1'b0, arg_a_list[i], 32'd0, rdata);
					check_value({name, " read"}, arg_b_list[i], rdata);
				end
				"G": begin
					check_value({name, " gpio_o"}, arg_a_list[i], 32'(gpio_out));
					check_value({name, " gpio_oe_o"}, arg_b_list[i], 32'(gpio_oe));
				end
				"D": check_disabled(arg_a_list[i], name);
				"F": check_frame(arg_a_list[i], arg_b_list[i], name);
				default: abort_run($sformatf("%s has an unknown command", name));
			endcase
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/vout_pkg.sv
logic/wb_addr_decode.sv
logic/gpio_regs.sv
logic/vtiming_regs.sv
logic/vtiming_gen.sv
logic/vout_top.sv
sim/tb_vout_top.sv

/* sim/vout_trace.txt */
# cmd  a         b         (all values hex, addresses are byte addresses)
# W addr data | R addr expected | F width height | G gpio_o gpio_oe | D idle_cycles
G 5 f
R 40021000 00000005
R 40021004 0000000f
W 40021004 00000003
W 40021000 0000000f
R 40021000 0000000b
R 40021004 00000003
G f 3
R 40030000 00000000
R 40010000 00000000
R 40010004 00000008
R 40010008 00000004
W 40010004 00000010
W 40010008 00000007
R 40010004 00000010
R 40010008 00000007
D 40
W 40010004 00000008
W 40010008 00000004
W 40010000 00000001
R 40010000 00000001
F 8 4
W 40010004 00000006
W 40010008 00000003
F 8 4
F 6 3
